//--- hw/rf_pkg.sv
package rf_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    // Register data width
    localparam int XLEN = 32;

    // Instruction id width, enough for 8 ids in flight
    localparam int ID_WIDTH = 3;

    // Register number, x0 to x31
    localparam int REG_ADDR_WIDTH = 5;

    ////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////

    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;

    typedef logic [ID_WIDTH-1:0] instr_id_t;

    // Issue FSM states
    // IDLE means no request is held, WAIT means the held request is stalled
    typedef enum logic {
        ISSUE_IDLE = 1'b0,
        ISSUE_WAIT = 1'b1
    } issue_state_t;

endpackage

//--- hw/issue_stage.sv
`timescale 1ns/1ps

module issue_stage
    import rf_pkg::*;
#(
    parameter int NUM_IDS = 8
) (
    input  logic      clk,
    input  logic      reset,

    // Request from the requester, held until issued
    input  logic      req_valid,
    input  logic      req_uses_rs1,
    input  logic      req_uses_rs2,
    input  reg_addr_t req_rs1,
    input  reg_addr_t req_rs2,
    input  reg_addr_t req_rd,

    // Operand conflicts from the register file
    input  logic      rs1_conflict,
    input  logic      rs2_conflict,

    // Request fields toward the register file
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    output reg_addr_t rd_addr,
    output logic      uses_rs1,
    output logic      uses_rs2,
    output logic      issue_pulse,
    output instr_id_t issue_id
);

    issue_state_t state;
    issue_state_t next_state;
    instr_id_t    next_id;

    // Request fields go straight through
    assign rs1_addr = req_rs1;
    assign rs2_addr = req_rs2;
    assign rd_addr  = req_rd;
    assign uses_rs1 = req_uses_rs1;
    assign uses_rs2 = req_uses_rs2;

    // Issue in the cycle both operands are free
    assign issue_pulse = req_valid & ~rs1_conflict & ~rs2_conflict;
    assign issue_id    = next_id;

    ////////////////////////////////////////////////////////////
    // Stall FSM
    ////////////////////////////////////////////////////////////

    always_comb begin
        next_state = state;
        case (state)
            ISSUE_IDLE: begin
                // Blocked request starts waiting
                if (req_valid && !issue_pulse)
                    next_state = ISSUE_WAIT;
            end
            ISSUE_WAIT: begin
                // Leave once it goes out, or the requester drops it
                if (issue_pulse || !req_valid)
                    next_state = ISSUE_IDLE;
            end
            default: next_state = ISSUE_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            state <= ISSUE_IDLE;
        else
            state <= next_state;
    end

    // Ids handed out in order, wrapping at NUM_IDS
    always_ff @(posedge clk) begin
        if (reset)
            next_id <= '0;
        else if (issue_pulse)
            next_id <= (next_id == instr_id_t'(NUM_IDS - 1)) ? '0 : next_id + 1'b1;
    end

endmodule

//--- hw/reg_inuse.sv
`timescale 1ns/1ps

module reg_inuse
    import rf_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    // Destination of the instruction being issued
    input  reg_addr_t issued_rd_addr,
    input  logic      issued,

    // Destination of a matching retire
    input  reg_addr_t retired_rd_addr,
    input  logic      retired,

    // Source lookups
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output logic      rs1_inuse,
    output logic      rs2_inuse
);

    // One bit per register, bit 0 stays clear
    logic [31:0] inuse;

    ////////////////////////////////////////////////////////////
    // Scoreboard update
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            inuse <= '0;
        end else begin
            // Retire clears the bit
            if (retired && retired_rd_addr != '0)
                inuse[retired_rd_addr] <= 1'b0;
            // Issue comes last so it wins on the same register
            if (issued && issued_rd_addr != '0)
                inuse[issued_rd_addr] <= 1'b1;
        end
    end

    // x0 reads as never in use
    assign rs1_inuse = inuse[rs1_addr];
    assign rs2_inuse = inuse[rs2_addr];

endmodule

//--- hw/register_file.sv
`timescale 1ns/1ps

module register_file
    import rf_pkg::*;
(
    input  logic            clk,
    input  logic            reset,

    // Issue side
    input  logic            issue_pulse,
    input  logic            uses_rs1,
    input  logic            uses_rs2,
    input  reg_addr_t       rs1_addr,
    input  reg_addr_t       rs2_addr,
    input  reg_addr_t       rd_addr,
    input  instr_id_t       issue_id,

    // Retire from the writeback buffer, rd is never x0 here
    input  logic            retiring,
    input  reg_addr_t       ret_rd,
    input  instr_id_t       ret_id,
    input  logic [XLEN-1:0] ret_data,

    // Forwarding lookup results
    input  logic            rs1_valid,
    input  logic            rs2_valid,
    input  logic [XLEN-1:0] rs1_fwd_data,
    input  logic [XLEN-1:0] rs2_fwd_data,

    // Operands back to issue
    output logic [XLEN-1:0] rs1_data,
    output logic [XLEN-1:0] rs2_data,
    output logic            rs1_conflict,
    output logic            rs2_conflict,

    // Last writers of the sources, for the forwarding lookup
    output instr_id_t       rs1_id,
    output instr_id_t       rs2_id
);

    logic [XLEN-1:0] regs [32];

    // Id of the newest issued writer of each register
    instr_id_t last_writer [32];

    logic rs1_inuse;
    logic rs2_inuse;
    logic retire_match;

    ////////////////////////////////////////////////////////////
    // Retire
    ////////////////////////////////////////////////////////////

    // Only the newest writer may update the register
    assign retire_match = retiring && (ret_id == last_writer[ret_rd]);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (retire_match) begin
            regs[ret_rd] <= ret_data;
        end
    end

    // Table entry follows every issue
    always_ff @(posedge clk) begin
        if (issue_pulse)
            last_writer[rd_addr] <= issue_id;
    end

    reg_inuse inuse (
        .clk             (clk),
        .reset           (reset),
        .issued_rd_addr  (rd_addr),
        .issued          (issue_pulse),
        .retired_rd_addr (ret_rd),
        .retired         (retire_match),
        .rs1_addr        (rs1_addr),
        .rs2_addr        (rs2_addr),
        .rs1_inuse       (rs1_inuse),
        .rs2_inuse       (rs2_inuse)
    );

    ////////////////////////////////////////////////////////////
    // Operand select
    ////////////////////////////////////////////////////////////

    assign rs1_id = last_writer[rs1_addr];
    assign rs2_id = last_writer[rs2_addr];

    // Pending register takes the forwarded result
    assign rs1_data = rs1_inuse ? rs1_fwd_data : regs[rs1_addr];
    assign rs2_data = rs2_inuse ? rs2_fwd_data : regs[rs2_addr];

    // Stall while the writer has not completed
    assign rs1_conflict = uses_rs1 & rs1_inuse & ~rs1_valid;
    assign rs2_conflict = uses_rs2 & rs2_inuse & ~rs2_valid;

endmodule

//--- hw/writeback_buffer.sv
`timescale 1ns/1ps

module writeback_buffer
    import rf_pkg::*;
#(
    parameter int NUM_IDS = 8
) (
    input  logic            clk,
    input  logic            reset,

    // Completion from the functional units
    input  logic            cmp_valid,
    input  instr_id_t       cmp_id,
    input  reg_addr_t       cmp_rd,
    input  logic [XLEN-1:0] cmp_data,

    // Issue frees the id's old entry
    input  logic            issue_pulse,
    input  instr_id_t       issue_id,

    // Forwarding lookup by last-writer id
    input  instr_id_t       rs1_id,
    input  instr_id_t       rs2_id,
    output logic            rs1_valid,
    output logic            rs2_valid,
    output logic [XLEN-1:0] rs1_fwd_data,
    output logic [XLEN-1:0] rs2_fwd_data,

    // Retire toward the register file
    output logic            retiring,
    output instr_id_t       ret_id,
    output reg_addr_t       ret_rd,
    output logic [XLEN-1:0] ret_data
);

    // Result store indexed by id
    logic [XLEN-1:0]    results [NUM_IDS];
    logic [NUM_IDS-1:0] result_valid;

    ////////////////////////////////////////////////////////////
    // Result store
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (cmp_valid)
            results[cmp_id] <= cmp_data;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= '0;
        end else begin
            // Reissued id starts out without a result
            if (issue_pulse)
                result_valid[issue_id] <= 1'b0;
            if (cmp_valid)
                result_valid[cmp_id] <= 1'b1;
        end
    end

    // Forwarding, visible the cycle after completion
    assign rs1_valid    = result_valid[rs1_id];
    assign rs2_valid    = result_valid[rs2_id];
    assign rs1_fwd_data = results[rs1_id];
    assign rs2_fwd_data = results[rs2_id];

    ////////////////////////////////////////////////////////////
    // Retire stage
    ////////////////////////////////////////////////////////////

    // x0 results are dropped here
    always_ff @(posedge clk) begin
        if (reset)
            retiring <= 1'b0;
        else
            retiring <= cmp_valid && (cmp_rd != '0);
    end

    // Payload, qualified by retiring
    always_ff @(posedge clk) begin
        ret_id   <= cmp_id;
        ret_rd   <= cmp_rd;
        ret_data <= cmp_data;
    end

endmodule

//--- hw/regfile_subsys.sv
`timescale 1ns/1ps

module regfile_subsys
    import rf_pkg::*;
#(
    parameter int NUM_IDS = 8
) (
    input  logic            clk,
    input  logic            reset,

    // Instruction request
    input  logic            req_valid,
    input  logic            req_uses_rs1,
    input  logic            req_uses_rs2,
    input  reg_addr_t       req_rs1,
    input  reg_addr_t       req_rs2,
    input  reg_addr_t       req_rd,

    // Completion
    input  logic            cmp_valid,
    input  instr_id_t       cmp_id,
    input  reg_addr_t       cmp_rd,
    input  logic [XLEN-1:0] cmp_data,

    // Issue result with operands
    output logic            issued,
    output instr_id_t       issued_id,
    output logic [XLEN-1:0] op1,
    output logic [XLEN-1:0] op2
);

    // Issue stage to register file
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    logic      uses_rs1;
    logic      uses_rs2;
    logic      rs1_conflict;
    logic      rs2_conflict;

    // Register file and writeback buffer
    instr_id_t       rs1_id;
    instr_id_t       rs2_id;
    logic            rs1_valid;
    logic            rs2_valid;
    logic [XLEN-1:0] rs1_fwd_data;
    logic [XLEN-1:0] rs2_fwd_data;

    // Retire path
    logic            retiring;
    instr_id_t       ret_id;
    reg_addr_t       ret_rd;
    logic [XLEN-1:0] ret_data;

    ////////////////////////////////////////////////////////////
    // Submodules
    ////////////////////////////////////////////////////////////

    issue_stage #(
        .NUM_IDS (NUM_IDS)
    ) issue (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .req_uses_rs1 (req_uses_rs1),
        .req_uses_rs2 (req_uses_rs2),
        .req_rs1      (req_rs1),
        .req_rs2      (req_rs2),
        .req_rd       (req_rd),
        .rs1_conflict (rs1_conflict),
        .rs2_conflict (rs2_conflict),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rd_addr      (rd_addr),
        .uses_rs1     (uses_rs1),
        .uses_rs2     (uses_rs2),
        .issue_pulse  (issued),
        .issue_id     (issued_id)
    );

    register_file rf (
        .clk          (clk),
        .reset        (reset),
        .issue_pulse  (issued),
        .uses_rs1     (uses_rs1),
        .uses_rs2     (uses_rs2),
        .rs1_addr     (rs1_addr),
        .rs2_addr     (rs2_addr),
        .rd_addr      (rd_addr),
        .issue_id     (issued_id),
        .retiring     (retiring),
        .ret_rd       (ret_rd),
        .ret_id       (ret_id),
        .ret_data     (ret_data),
        .rs1_valid    (rs1_valid),
        .rs2_valid    (rs2_valid),
        .rs1_fwd_data (rs1_fwd_data),
        .rs2_fwd_data (rs2_fwd_data),
        .rs1_data     (op1),
        .rs2_data     (op2),
        .rs1_conflict (rs1_conflict),
        .rs2_conflict (rs2_conflict),
        .rs1_id       (rs1_id),
        .rs2_id       (rs2_id)
    );

    writeback_buffer #(
        .NUM_IDS (NUM_IDS)
    ) wb (
        .clk          (clk),
        .reset        (reset),
        .cmp_valid    (cmp_valid),
        .cmp_id       (cmp_id),
        .cmp_rd       (cmp_rd),
        .cmp_data     (cmp_data),
        .issue_pulse  (issued),
        .issue_id     (issued_id),
        .rs1_id       (rs1_id),
        .rs2_id       (rs2_id),
        .rs1_valid    (rs1_valid),
        .rs2_valid    (rs2_valid),
        .rs1_fwd_data (rs1_fwd_data),
        .rs2_fwd_data (rs2_fwd_data),
        .retiring     (retiring),
        .ret_id       (ret_id),
        .ret_rd       (ret_rd),
        .ret_data     (ret_data)
    );

endmodule

//--- bench/regfile_subsys_tb.sv
`timescale 1ns/1ps

module regfile_subsys_tb
    import rf_pkg::*;
();

    localparam int NUM_IDS       = 8;
    localparam int CLK_PERIOD    = 20;
    localparam int RANDOM_CYCLES = 2000;
    // Directed tests need well under 2000 cycles
    localparam int MAX_CYCLES    = RANDOM_CYCLES + 2000;

    logic            clk;
    logic            reset;
    logic            req_valid;
    logic            req_uses_rs1;
    logic            req_uses_rs2;
    reg_addr_t       req_rs1;
    reg_addr_t       req_rs2;
    reg_addr_t       req_rd;
    logic            cmp_valid;
    instr_id_t       cmp_id;
    reg_addr_t       cmp_rd;
    logic [XLEN-1:0] cmp_data;
    logic            issued;
    instr_id_t       issued_id;
    logic [XLEN-1:0] op1;
    logic [XLEN-1:0] op2;

    // Reference model, latest issued writer per register
    logic [XLEN-1:0] model [32];
    bit              pend [32];
    instr_id_t       wr_id [32];
    logic [XLEN-1:0] data_of [NUM_IDS];
    reg_addr_t       rd_of [NUM_IDS];
    bit              busy [NUM_IDS];

    // Expected response for the request on the inputs
    logic            exp_stall;
    logic            chk1;
    logic            chk2;
    logic [XLEN-1:0] exp_op1;
    logic [XLEN-1:0] exp_op2;
    instr_id_t       exp_id;

    instr_id_t last_id;
    bit        saw_issue;
    int        seed = 32'h42a0_ad6d;
    int        cycles = 0;
    int        errors = 0;
    int        err_start;
    int        n_tests = 0;
    int        n_passed = 0;
    int        n_issued = 0;

    regfile_subsys #(.NUM_IDS(NUM_IDS)) DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Hard stop for a stuck request or lost completion
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout after %0d cycles, the run never finished", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Checks, sampled at the rising edge
    ////////////////////////////////////////////////////////////

    a_op1: assert property (@(posedge clk) disable iff (reset)
        issued && chk1 |-> op1 == exp_op1)
        else value_error("op1", $sampled(op1), $sampled(exp_op1));
    a_op2: assert property (@(posedge clk) disable iff (reset)
        issued && chk2 |-> op2 == exp_op2)
        else value_error("op2", $sampled(op2), $sampled(exp_op2));
    a_id: assert property (@(posedge clk) disable iff (reset)
        issued |-> issued_id == exp_id)
        else value_error("issued_id", XLEN'($sampled(issued_id)), XLEN'($sampled(exp_id)));
    a_stall: assert property (@(posedge clk) disable iff (reset)
        req_valid && exp_stall |-> !issued)
        else event_error("request issued while a source was still pending");
    a_free: assert property (@(posedge clk) disable iff (reset)
        req_valid && !exp_stall |-> issued)
        else event_error("request with free sources did not issue");

    task automatic value_error(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        errors++;
        $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
    endtask

    task automatic event_error(input string what);
        errors++;
        $display("at %0t: %s", $time, what);
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus and model helpers
    ////////////////////////////////////////////////////////////

    task automatic set_expect();
        exp_stall = req_valid && ((req_uses_rs1 && pend[req_rs1]) ||
                                  (req_uses_rs2 && pend[req_rs2]));
        exp_op1 = model[req_rs1];
        exp_op2 = model[req_rs2];
        chk1    = req_uses_rs1;
        chk2    = req_uses_rs2;
    endtask

    task automatic present(input reg_addr_t rs1, input reg_addr_t rs2, input reg_addr_t rd,
                           input logic u1, input logic u2);
        req_valid    = 1'b1;
        req_rs1      = rs1;
        req_rs2      = rs2;
        req_rd       = rd;
        req_uses_rs1 = u1;
        req_uses_rs2 = u2;
        set_expect();
    endtask

    task automatic present_random();
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        logic      u1;
        logic      u2;
        // Only x0 to x7, so conflicts are frequent
        rs1 = reg_addr_t'($random(seed) & 7);
        rs2 = reg_addr_t'($random(seed) & 7);
        rd  = reg_addr_t'($random(seed) & 7);
        u1  = 1'($random(seed));
        u2  = 1'($random(seed));
        present(rs1, rs2, rd, u1, u2);
    endtask

    // New writer, its result data is fixed here
    task automatic record_issue();
        data_of[exp_id] = $random(seed);
        rd_of[exp_id]   = req_rd;
        busy[exp_id]    = 1'b1;
        if (req_rd != '0) begin
            model[req_rd] = data_of[exp_id];
            pend[req_rd]  = 1'b1;
            wr_id[req_rd] = exp_id;
        end
        last_id = exp_id;
        exp_id  = exp_id + 1'b1;
        n_issued++;
    endtask

    task automatic complete(input instr_id_t id);
        cmp_valid = 1'b1;
        cmp_id    = id;
        cmp_rd    = rd_of[id];
        cmp_data  = data_of[id];
    endtask

    // One clock, called and returning at a falling edge
    task automatic tick();
        #(CLK_PERIOD / 2 - 1);
        saw_issue = issued;
        @(negedge clk);
        if (cmp_valid) begin
            busy[cmp_id] = 1'b0;
            // Older writers do not release the register
            if (pend[cmp_rd] && wr_id[cmp_rd] == cmp_id)
                pend[cmp_rd] = 1'b0;
            cmp_valid = 1'b0;
        end
        if (saw_issue) begin
            record_issue();
            req_valid = 1'b0;
        end
        set_expect();
    endtask

    task automatic wait_issue();
        do
            tick();
        while (!saw_issue);
    endtask

    task automatic issue_one(input reg_addr_t rs1, input reg_addr_t rs2, input reg_addr_t rd,
                             input logic u1, input logic u2);
        present(rs1, rs2, rd, u1, u2);
        wait_issue();
    endtask

    task automatic pick_busy(output bit found, output instr_id_t id);
        int start;
        start = $random(seed) & 7;
        found = 1'b0;
        id    = '0;
        for (int k = 0; k < NUM_IDS; k++) begin
            if (!found && busy[(start + k) % NUM_IDS]) begin
                found = 1'b1;
                id    = instr_id_t'((start + k) % NUM_IDS);
            end
        end
    endtask

    // Ids issued and not yet completed
    function automatic int count_busy();
        int n;
        n = 0;
        for (int i = 0; i < NUM_IDS; i++)
            if (busy[i])
                n++;
        return n;
    endfunction

    task automatic begin_test();
        err_start = errors;
    endtask

    task automatic end_test(input string name);
        n_tests++;
        if (errors == err_start) begin
            n_passed++;
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - err_start);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        instr_id_t wa;
        instr_id_t wb;
        instr_id_t cid;
        bit        found;

        reset        = 1'b1;
        req_valid    = 1'b0;
        req_uses_rs1 = 1'b0;
        req_uses_rs2 = 1'b0;
        req_rs1      = '0;
        req_rs2      = '0;
        req_rd       = '0;
        cmp_valid    = 1'b0;
        cmp_id       = '0;
        cmp_rd       = '0;
        cmp_data     = '0;
        exp_id       = '0;
        for (int r = 0; r < 32; r++) begin
            model[r] = '0;
            pend[r]  = 1'b0;
            wr_id[r] = '0;
        end
        for (int i = 0; i < NUM_IDS; i++)
            busy[i] = 1'b0;
        set_expect();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Everything reads zero after reset
        begin_test();
        for (int r = 0; r < 32; r += 4) begin
            issue_one(reg_addr_t'(r), reg_addr_t'(31 - r), '0, 1'b1, 1'b1);
            complete(last_id);
            tick();
        end
        end_test("reset_reads");

        // Retired x5 result read back
        begin_test();
        issue_one('0, '0, 5'd5, 1'b0, 1'b0);
        wa = last_id;
        repeat (2) tick();
        complete(wa);
        repeat (3) tick();
        issue_one(5'd5, 5'd5, '0, 1'b1, 1'b1);
        complete(last_id);
        tick();
        end_test("retire_read");

        // Stall on x7, forwarded first, then from the array
        begin_test();
        issue_one('0, '0, 5'd7, 1'b0, 1'b0);
        wa = last_id;
        present(5'd7, 5'd5, '0, 1'b1, 1'b1);
        repeat (4) tick();
        complete(wa);
        wait_issue();
        complete(last_id);
        repeat (2) tick();
        issue_one(5'd7, 5'd7, '0, 1'b1, 1'b1);
        complete(last_id);
        tick();
        end_test("stall_forward");

        // x0 writer pending, reader must not wait
        begin_test();
        issue_one('0, '0, '0, 1'b0, 1'b0);
        wa = last_id;
        issue_one('0, '0, '0, 1'b1, 1'b1);
        wb = last_id;
        complete(wa);
        tick();
        complete(wb);
        repeat (3) tick();
        issue_one('0, '0, '0, 1'b1, 1'b1);
        complete(last_id);
        tick();
        end_test("x0_zero");

        // Two writers of x9, older one completes first
        begin_test();
        issue_one('0, '0, 5'd9, 1'b0, 1'b0);
        wa = last_id;
        issue_one('0, '0, 5'd9, 1'b0, 1'b0);
        wb = last_id;
        present(5'd9, '0, '0, 1'b1, 1'b0);
        repeat (2) tick();
        complete(wa);
        repeat (3) tick();
        complete(wb);
        wait_issue();
        complete(last_id);
        tick();
        end_test("waw_newest");

        // Random issues, out of order completions
        begin_test();
        for (int c = 0; c < RANDOM_CYCLES; c++) begin
            // Fewer than 8 ids in flight, counting the next issue
            if (!req_valid && !busy[exp_id] && count_busy() < NUM_IDS - 1 &&
                ($random(seed) & 3) != 0)
                present_random();
            pick_busy(found, cid);
            if (found && ($random(seed) & 1) != 0)
                complete(cid);
            tick();
        end
        // Drain held request and outstanding ids
        pick_busy(found, cid);
        while (req_valid || found) begin
            if (found)
                complete(cid);
            tick();
            pick_busy(found, cid);
        end
        end_test("random_mix");

        $display("%0d of %0d tests passed, %0d issues checked, %0d errors",
                 n_passed, n_tests, n_issued, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- regfile_subsys.f
hw/rf_pkg.sv
hw/issue_stage.sv
hw/reg_inuse.sv
hw/register_file.sv
hw/writeback_buffer.sv
hw/regfile_subsys.sv
bench/regfile_subsys_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := regfile_subsys_tb
RTL_TOP    := regfile_subsys
FILELIST   := regfile_subsys.f
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_TEXT  := PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
